//--- sim.f
+incdir+include
src/spi_pkg.sv
src/spi_host_shifter.sv
src/spi_burst_sequencer.sv
src/spi_host_top.sv
verification/tb_clock_gen.sv
verification/tb_spi_device.sv
verification/tb_checker.sv
verification/tb_top.sv

//--- Makefile
# Verilator build and run of the SPI host testbench

VERILATOR ?= verilator
TOP ?= tb_top
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG ?= sim passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- verification/tb_top.sv
`timescale 1ns/10ps
`include "spi_settings.svh"

module tb_top;

	localparam int rows = 8;
	localparam int byte_w = `SPI_BYTE_WIDTH;
	localparam int word_w = `SPI_WORD_WIDTH;
	localparam int len_w = `SPI_LEN_WIDTH;
	localparam int div_w = `SPI_CLKDIV_WIDTH;
	localparam int drive_delay = 1;

	logic clk;
	logic arst_n;
	logic start;
	logic [len_w-1:0] burst_len;
	logic [word_w-1:0] tx_word;
	logic [div_w-1:0] clkdiv;
	logic [word_w-1:0] exp_rx;
	logic busy;
	logic done;
	logic [word_w-1:0] rx_word;
	logic spi_cs_n;
	logic spi_sck;
	logic spi_mosi;
	logic spi_miso;

	int tests_run;
	int tests_failed;
	int errors;
	int cycles = 0;
	int limit = 0;

	// Test table with one command per row
	logic [len_w-1:0] table_len [rows];
	logic [word_w-1:0] table_tx [rows];
	logic [div_w-1:0] table_div [rows];
	logic [word_w-1:0] table_exp [rows];
	int table_gap [rows];
	bit table_poke [rows];

	tb_clock_gen clk_gen_i (.clk(clk), .arst_n(arst_n));

	spi_host_top dut_i (
		.clk(clk), .arst_n(arst_n), .start(start), .burst_len(burst_len),
		.tx_word(tx_word), .clkdiv(clkdiv), .busy(busy), .done(done), .rx_word(rx_word),
		.spi_cs_n(spi_cs_n), .spi_sck(spi_sck), .spi_mosi(spi_mosi), .spi_miso(spi_miso)
	);

	tb_spi_device device_i (
		.spi_cs_n(spi_cs_n), .spi_sck(spi_sck), .spi_mosi(spi_mosi), .spi_miso(spi_miso)
	);

	tb_checker checker_i (
		.clk(clk), .arst_n(arst_n), .start(start), .burst_len(burst_len), .clkdiv(clkdiv),
		.exp_rx(exp_rx), .busy(busy), .done(done), .rx_word(rx_word), .spi_cs_n(spi_cs_n),
		.spi_sck(spi_sck), .spi_mosi(spi_mosi),
		.tests_run(tests_run), .tests_failed(tests_failed), .errors(errors)
	);

	// Expected rx word by the device rule
	// First byte 3C and each later one the inverse of the tx byte before it
	function automatic logic [word_w-1:0] predict_rx(input int len, input logic [word_w-1:0] tx);
		logic [word_w-1:0] word;
		logic [byte_w-1:0] answer;
		int k;
		word = '0;
		for (k = 0; k < len; k++) begin
			if (k == 0) answer = 8'h3C;
			else answer = ~tx[word_w-1-(k-1)*byte_w -: byte_w];
			word[word_w-1-k*byte_w -: byte_w] = answer;
		end
		return word;
	endfunction

	task automatic set_row(input int r, input int len, input int div, input int gap,
		input bit poke);
		table_len[r] = len_w'(len);
		table_tx[r] = $urandom;
		table_div[r] = div_w'(div);
		table_gap[r] = gap;
		table_poke[r] = poke;
		table_exp[r] = predict_rx(len, table_tx[r]);
	endtask

	task automatic apply_row(input int r);
		repeat (table_gap[r]) begin
			@(posedge clk);
			#drive_delay;
		end
		start = 1'b1;
		burst_len = table_len[r];
		tx_word = table_tx[r];
		clkdiv = table_div[r];
		exp_rx = table_exp[r];
		@(posedge clk);
		#drive_delay;
		start = 1'b0;
		// Second start while busy must be dropped
		if (table_poke[r]) begin
			repeat (3) @(posedge clk);
			#drive_delay;
			start = 1'b1;
			tx_word = ~table_tx[r];
			@(posedge clk);
			#drive_delay;
			start = 1'b0;
		end
		while (done !== 1'b1) begin
			@(posedge clk);
			#drive_delay;
		end
	endtask

	////////////////////
	// Run limit

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("timeout after %0d cycles, the DUT never finished the test table", cycles);
			$display("sim failed");
			$finish;
		end
	end

	initial begin
		start = 1'b0;
		burst_len = len_w'(1);
		tx_word = '0;
		clkdiv = '0;
		exp_rx = '0;
		void'($urandom(32'h55143d91));
		// Rows with gap 0 start in the done cycle of the row before
		set_row(0, 1, 0, 3, 1'b0);
		set_row(1, 4, 1, 2, 1'b0);
		set_row(2, 4, 6, 2, 1'b0);
		set_row(3, 2, 40, 1, 1'b0);
		set_row(4, 3, 6, 2, 1'b1);
		set_row(5, 4, 2, 0, 1'b0);
		set_row(6, 1, 0, 0, 1'b0);
		set_row(7, int'($urandom_range(4, 1)), int'($urandom_range(15, 0)), 0, 1'b0);
		for (int r = 0; r < rows; r++) begin
			limit += int'(table_len[r]) * 16 * (int'(table_div[r]) / 2 + 1) + 50;
		end
		wait (arst_n === 1'b1);
		@(posedge clk);
		#drive_delay;
		for (int r = 0; r < rows; r++) begin
			apply_row(r);
		end
		// Catch any stray done pulse
		repeat (4) @(posedge clk);
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0 && tests_run == rows + 1) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- verification/tb_checker.sv
`timescale 1ns/10ps
`include "spi_settings.svh"

module tb_checker (
	input logic clk,
	input logic arst_n,
	// Command side as the DUT sees it
	input logic start,
	input logic [`SPI_LEN_WIDTH-1:0] burst_len,
	input logic [`SPI_CLKDIV_WIDTH-1:0] clkdiv,
	input logic [`SPI_WORD_WIDTH-1:0] exp_rx,
	// DUT outputs
	input logic busy,
	input logic done,
	input logic [`SPI_WORD_WIDTH-1:0] rx_word,
	input logic spi_cs_n,
	input logic spi_sck,
	input logic spi_mosi,
	output int tests_run,
	output int tests_failed,
	output int errors
);

	localparam int word_w = `SPI_WORD_WIDTH;

	bit armed;
	bit reset_seen;
	int row_errors;
	int cur_len;
	int cur_div;
	logic [word_w-1:0] exp_word;

	task automatic report_value(input string name, input logic [word_w-1:0] expected,
		input logic [word_w-1:0] actual);
		$display("error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
		errors++;
		row_errors++;
	endtask

	// Single-bit compare, X counts as wrong
	task automatic expect_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			report_value(name, word_w'(expected), word_w'(actual));
		end
	endtask

	task automatic close_test(input string what);
		tests_run++;
		if (row_errors == 0) begin
			$display("test %0d, %s: ok", tests_run, what);
		end else begin
			tests_failed++;
			$display("test %0d, %s: %0d mismatches", tests_run, what, row_errors);
		end
		row_errors = 0;
	endtask

	////////////////////
	// Sampled on the rising edge while inputs move 1 ns later

	always @(posedge clk) begin
		if (!arst_n) begin
			armed = 1'b0;
			reset_seen = 1'b0;
			row_errors = 0;
		end else begin
			// First cycle out of reset
			if (!reset_seen) begin
				reset_seen = 1'b1;
				expect_bit("spi_cs_n", 1'b1, spi_cs_n);
				expect_bit("spi_sck", 1'b0, spi_sck);
				expect_bit("spi_mosi", 1'b0, spi_mosi);
				expect_bit("busy", 1'b0, busy);
				expect_bit("done", 1'b0, done);
				close_test("reset state");
			end
			if (done === 1'b1) begin
				if (!armed) begin
					$display("done pulsed at %0t ns with no command pending", $time);
					errors++;
				end else begin
					// Chip select rises together with done
					expect_bit("spi_cs_n", 1'b1, spi_cs_n);
					if (rx_word !== exp_word) report_value("rx_word", exp_word, rx_word);
					close_test($sformatf("len %0d clkdiv %0d rx_word %08h",
						cur_len, cur_div, rx_word));
					armed = 1'b0;
				end
			end else if (armed) begin
				// Frame stays open for the whole burst
				expect_bit("spi_cs_n", 1'b0, spi_cs_n);
			end
			// A start during busy is dropped
			if (start === 1'b1 && busy === 1'b0) begin
				armed = 1'b1;
				exp_word = exp_rx;
				cur_len = int'(burst_len);
				cur_div = int'(clkdiv);
				row_errors = 0;
			end
		end
	end

endmodule

//--- verification/tb_spi_device.sv
`timescale 1ns/10ps

module tb_spi_device (
	input logic spi_cs_n,
	input logic spi_sck,
	input logic spi_mosi,
	output logic spi_miso
);

	// Fixed answer for the first byte of every frame
	localparam logic [7:0] first_answer = 8'h3C;

	logic cs_q = 1'b1;
	logic miso_q = 1'b0;
	logic [7:0] tx_byte = 8'h00;
	logic [7:0] rx_byte = 8'h00;
	int bit_cnt = 0;

	assign spi_miso = miso_q;

	// Mode 0 device, samples on rising SCK and changes MISO on falling SCK
	always @(posedge spi_cs_n or negedge spi_cs_n or posedge spi_sck or negedge spi_sck) begin
		if (spi_cs_n !== cs_q) begin
			cs_q = spi_cs_n;
			// New frame, first bit goes out with chip select
			if (!spi_cs_n) begin
				tx_byte = first_answer;
				bit_cnt = 0;
				miso_q = tx_byte[7];
			end
		end else if (!spi_cs_n) begin
			if (spi_sck) begin
				rx_byte = {rx_byte[6:0], spi_mosi};
				bit_cnt++;
			end else begin
				// Byte complete, answer with its inverse next
				if (bit_cnt == 8) begin
					tx_byte = ~rx_byte;
					bit_cnt = 0;
				end else begin
					tx_byte = {tx_byte[6:0], 1'b0};
				end
				miso_q = tx_byte[7];
			end
		end
	end

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk,
	output logic arst_n
);

	// 4 ns period, first rising edge at 2 ns
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Reset held over two rising edges, released just after the second
	initial begin
		arst_n = 1'b0;
		repeat (2) @(posedge clk);
		#1 arst_n = 1'b1;
	end

endmodule

//--- src/spi_host_top.sv
`timescale 1ns/10ps
`include "spi_settings.svh"

module spi_host_top #(
	parameter spi_pkg::sample_edge_t sample_edge = spi_pkg::sample_rising,
	parameter spi_pkg::local_edge_t local_edge = spi_pkg::local_normal,
	parameter bit change_on_done = 1'b1
) (
	input logic clk,
	input logic arst_n,
	// Command side
	input logic start,
	input logic [`SPI_LEN_WIDTH-1:0] burst_len,
	input logic [`SPI_WORD_WIDTH-1:0] tx_word,
	input logic [`SPI_CLKDIV_WIDTH-1:0] clkdiv,
	output logic busy,
	output logic done,
	output logic [`SPI_WORD_WIDTH-1:0] rx_word,
	// SPI pins
	output logic spi_cs_n,
	output logic spi_sck,
	output logic spi_mosi,
	input logic spi_miso
);

	// Byte handoff between sequencer and shifter
	logic shift_en;
	logic shift_done;
	logic [`SPI_BYTE_WIDTH-1:0] tx_data;
	logic [`SPI_BYTE_WIDTH-1:0] rx_data;

	spi_burst_sequencer seq_i (
		.clk(clk),
		.arst_n(arst_n),
		.start(start),
		.burst_len(burst_len),
		.tx_word(tx_word),
		.rx_word(rx_word),
		.busy(busy),
		.done(done),
		.spi_cs_n(spi_cs_n),
		.shift_en(shift_en),
		.tx_data(tx_data),
		.shift_done(shift_done),
		.rx_data(rx_data)
	);

	spi_host_shifter #(
		.sample_edge(sample_edge),
		.local_edge(local_edge),
		.change_on_done(change_on_done)
	) shifter_i (
		.clk(clk),
		.arst_n(arst_n),
		.clkdiv(clkdiv),
		.shift_en(shift_en),
		.tx_data(tx_data),
		.spi_miso(spi_miso),
		.spi_sck(spi_sck),
		.spi_mosi(spi_mosi),
		.shift_done(shift_done),
		.rx_data(rx_data)
	);

endmodule

//--- src/spi_burst_sequencer.sv
`timescale 1ns/10ps
`include "spi_settings.svh"

module spi_burst_sequencer (
	input logic clk,
	input logic arst_n,
	input logic start,
	input logic [`SPI_LEN_WIDTH-1:0] burst_len,
	input logic [`SPI_WORD_WIDTH-1:0] tx_word,
	output logic [`SPI_WORD_WIDTH-1:0] rx_word,
	output logic busy,
	output logic done,
	output logic spi_cs_n,
	output logic shift_en,
	output logic [`SPI_BYTE_WIDTH-1:0] tx_data,
	input logic shift_done,
	input logic [`SPI_BYTE_WIDTH-1:0] rx_data
);

	localparam int byte_w = `SPI_BYTE_WIDTH;
	localparam int word_w = `SPI_WORD_WIDTH;
	localparam int len_w = `SPI_LEN_WIDTH;
	localparam logic [len_w-1:0] max_len = len_w'(`SPI_MAX_BURST);

	spi_pkg::seq_state_t state;

	logic kick;
	logic in_flight;
	logic [len_w-1:0] len_q;
	logic [len_w-1:0] bytes_left;
	logic [len_w-1:0] pad_bytes;
	logic [word_w-1:0] tx_shreg;
	logic [word_w-1:0] rx_shreg;
	logic [word_w-1:0] rx_packed;
	logic [word_w-1:0] rx_aligned;
	logic accept;
	logic byte_end;
	logic last_byte;

	////////////////////
	// Status and decode

	assign busy = (state == spi_pkg::seq_shifting);
	assign done = (state == spi_pkg::seq_finish);

	// Commands only land while not busy
	assign accept = start && !busy;

	// Only count shift_done pulses that belong to this burst
	assign byte_end = shift_done && in_flight;
	// Zero-length bursts fall out here too
	assign last_byte = byte_end && (bytes_left <= len_w'(1));

	// Next outgoing byte sits at the top
	assign tx_data = tx_shreg[word_w-1 -: byte_w];

	// Fold in the final byte and push the burst up to the top
	assign rx_packed = {rx_shreg[word_w-byte_w-1:0], rx_data};
	assign pad_bytes = max_len - len_q;
	assign rx_aligned = rx_packed << (pad_bytes * byte_w);

	////////////////////
	// Burst FSM

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= spi_pkg::seq_idle;
			kick <= 1'b0;
			in_flight <= 1'b0;
			len_q <= '0;
			bytes_left <= '0;
			spi_cs_n <= 1'b1;
			shift_en <= 1'b0;
		end else begin
			shift_en <= 1'b0;
			kick <= 1'b0;
			case (state)
				spi_pkg::seq_idle,
				spi_pkg::seq_finish: begin
					// Finish lasts one cycle, a new command may start in it
					state <= spi_pkg::seq_idle;
					if (accept) begin
						state <= spi_pkg::seq_shifting;
						spi_cs_n <= 1'b0;
						kick <= 1'b1;
						len_q <= burst_len;
						bytes_left <= burst_len;
					end
				end

				spi_pkg::seq_shifting: begin
					// First byte one cycle after chip select falls
					if (kick) begin
						shift_en <= 1'b1;
						in_flight <= 1'b1;
					end
					if (last_byte) begin
						// End of frame
						in_flight <= 1'b0;
						spi_cs_n <= 1'b1;
						state <= spi_pkg::seq_finish;
					end else if (byte_end) begin
						// Next byte right behind shift_done
						shift_en <= 1'b1;
						bytes_left <= bytes_left - 1'b1;
					end
				end

				default: begin
					state <= spi_pkg::seq_idle;
					spi_cs_n <= 1'b1;
					in_flight <= 1'b0;
				end
			endcase
		end
	end

	////////////////////
	// Data words

	always_ff @(posedge clk) begin
		// Local copy of tx_word, moves up one byte per shift
		if (accept) begin
			tx_shreg <= tx_word;
		end else if (shift_en) begin
			tx_shreg <= tx_shreg << byte_w;
		end
		if (byte_end) begin
			rx_shreg <= rx_packed;
		end
		// Result holds until the next command
		if (last_byte) begin
			rx_word <= rx_aligned;
		end
	end

	////////////////////
	// Checks

	// Shifter activity only inside a chip-select frame
	a_cs_framed: assert property (@(posedge clk) disable iff (!arst_n)
		(shift_en || shift_done) |-> !spi_cs_n);

	a_done_alone: assert property (@(posedge clk) disable iff (!arst_n)
		!(done && shift_en));

	// Length is only meaningful on an accepted command
	a_len_range: assert property (@(posedge clk) disable iff (!arst_n)
		accept |-> ((burst_len >= len_w'(1)) && (burst_len <= max_len)));

endmodule

//--- src/spi_host_shifter.sv
`timescale 1ns/10ps
`include "spi_settings.svh"

module spi_host_shifter #(
	parameter spi_pkg::sample_edge_t sample_edge = spi_pkg::sample_rising,
	parameter spi_pkg::local_edge_t local_edge = spi_pkg::local_normal,
	parameter bit change_on_done = 1'b0
) (
	input logic clk,
	input logic arst_n,
	input logic [`SPI_CLKDIV_WIDTH-1:0] clkdiv,
	input logic shift_en,
	input logic [`SPI_BYTE_WIDTH-1:0] tx_data,
	input logic spi_miso,
	output logic spi_sck,
	output logic spi_mosi,
	output logic shift_done,
	output logic [`SPI_BYTE_WIDTH-1:0] rx_data
);

	localparam int byte_w = `SPI_BYTE_WIDTH;
	// Half-period counter drops the low divisor bit
	localparam int half_w = `SPI_CLKDIV_WIDTH - 1;
	localparam int cnt_w = $clog2(byte_w + 2);
	localparam logic [cnt_w-1:0] bits_all = cnt_w'(byte_w);
	localparam logic [cnt_w-1:0] bits_max = cnt_w'(byte_w + 1);
	// SCK level just before the remote sample edge
	localparam logic sck_pre = (sample_edge == spi_pkg::sample_falling);

	logic active;
	logic [cnt_w-1:0] count;
	logic [half_w-1:0] half_cnt;
	logic [half_w-1:0] half_lim;
	logic [byte_w-2:0] tx_shreg;
	logic [byte_w-1:0] rx_shreg;
	logic sample_pending;
	logic shift_done_adv;
	logic tick;
	logic remote_edge;
	logic launch_edge;
	logic tail;
	logic rx_sample;

	////////////////////
	// Edge decode

	assign half_lim = clkdiv[`SPI_CLKDIV_WIDTH-1:1];

	// Half period over, a new shift_en overrides everything
	assign tick = active && !shift_en && (half_cnt >= half_lim);

	// All eight remote edges seen, only the return to idle is left
	assign tail = (count == bits_all);

	// Remote device samples here
	assign remote_edge = tick && !tail && (spi_sck == sck_pre);

	// MOSI moves to the next bit here
	assign launch_edge = tick && !tail && (spi_sck != sck_pre);

	// Inverted mode takes MISO one half period after each remote edge
	assign rx_sample = (local_edge == spi_pkg::local_normal) ? remote_edge :
		(tick && sample_pending);

	////////////////////
	// Control

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active <= 1'b0;
			count <= '0;
			half_cnt <= '0;
			spi_sck <= 1'b0;
			spi_mosi <= 1'b0;
			sample_pending <= 1'b0;
			shift_done_adv <= 1'b0;
		end else begin
			shift_done_adv <= 1'b0;
			if (shift_en) begin
				// MSB goes out at once
				active <= 1'b1;
				count <= '0;
				half_cnt <= '0;
				sample_pending <= 1'b0;
				spi_sck <= sck_pre;
				spi_mosi <= tx_data[byte_w-1];
			end else if (active) begin
				if (!tick) begin
					half_cnt <= half_cnt + 1'b1;
				end else begin
					half_cnt <= '0;
					sample_pending <= 1'b0;
					if (tail) begin
						// Bring SCK back low, then hold half a bit before done
						if (spi_sck) begin
							spi_sck <= 1'b0;
						end else begin
							active <= 1'b0;
							shift_done_adv <= 1'b1;
						end
					end else if (remote_edge) begin
						spi_sck <= !spi_sck;
						count <= count + 1'b1;
						sample_pending <= 1'b1;
					end else begin
						spi_sck <= !spi_sck;
						spi_mosi <= tx_shreg[byte_w-2];
					end
				end
			end
		end
	end

	////////////////////
	// Shift registers

	always_ff @(posedge clk) begin
		if (shift_en) begin
			tx_shreg <= tx_data[byte_w-2:0];
		end else if (launch_edge) begin
			tx_shreg <= {tx_shreg[byte_w-3:0], 1'b0};
		end
		// MSB first, so the newest bit enters at the bottom
		if (rx_sample) begin
			rx_shreg <= {rx_shreg[byte_w-2:0], spi_miso};
		end
	end

	////////////////////
	// Result stage

	generate
		if (change_on_done) begin : g_gated
			// rx_data only moves with shift_done, one cycle later
			always_ff @(posedge clk or negedge arst_n) begin
				if (!arst_n) begin
					shift_done <= 1'b0;
				end else begin
					shift_done <= shift_done_adv;
				end
			end

			always_ff @(posedge clk) begin
				if (shift_done_adv) begin
					rx_data <= rx_shreg;
				end
			end
		end else begin : g_direct
			assign shift_done = shift_done_adv;
			assign rx_data = rx_shreg;
		end
	endgenerate

	////////////////////
	// Checks

	// Sequencer must wait for the byte to finish
	a_no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
		shift_en |-> !active);

	// Divisor must stay put while a byte is on the wire
	a_half_cnt: assert property (@(posedge clk) disable iff (!arst_n)
		active |-> (half_cnt <= half_lim));

	a_bit_cnt: assert property (@(posedge clk) disable iff (!arst_n)
		count <= bits_max);

endmodule

//--- src/spi_pkg.sv
package spi_pkg;

	////////////////////
	// Shifter edge options

	// SCK edge on which the remote device samples MOSI
	typedef enum logic {
		sample_rising,
		sample_falling
	} sample_edge_t;

	// Host MISO sampling relative to the remote sample edge
	// Normal samples on the same edge, inverted half a bit later
	typedef enum logic {
		local_normal,
		local_inverted
	} local_edge_t;

	////////////////////
	// Burst sequencer

	// Idle waits for a command, finish is the single done cycle
	typedef enum logic [1:0] {
		seq_idle,
		seq_shifting,
		seq_finish
	} seq_state_t;

endpackage

//--- include/spi_settings.svh
`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

////////////////////
// SPI sizing

// Width of the runtime SCK divisor input
`define SPI_CLKDIV_WIDTH 16

// Bits shifted per byte on the wire
`define SPI_BYTE_WIDTH 8

// Longest burst the sequencer accepts
`define SPI_MAX_BURST 4

// Command and result words hold a full burst
`define SPI_WORD_WIDTH (`SPI_BYTE_WIDTH * `SPI_MAX_BURST)

// Enough bits to count 1 to SPI_MAX_BURST bytes
`define SPI_LEN_WIDTH $clog2(`SPI_MAX_BURST + 1)

`endif
